// File: flist.f
verilog/ppu_pkg.sv
verilog/ppu_regs.sv
verilog/oam_dma.sv
verilog/ppu_mem.sv
verilog/ppu_reg_top.sv
tb/tb_clock.sv
tb/ppu_reg_tb.sv

// File: run.sh
#!/bin/sh
# build and run the register block testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f flist.f --top-module ppu_reg_tb -Mdir obj_dir -o ppu_reg_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ppu_reg_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation log has no result line"
    exit 1
fi
exit 0

// File: tb/ppu_reg_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ppu_reg_tb;
    import ppu_pkg::*;

    localparam int CLK_NS = 10;
    localparam int N_DATA = 16;
    localparam int N_PAL  = 8;
    // two dma runs with full readback, plus the short register tests
    localparam int TEST_CPU_CYCLES = 2 * (513 + 256 + 4) + 4 * (N_DATA + N_PAL) + 200;
    localparam int WATCHDOG_NS = 2 * (10 + 3 * TEST_CPU_CYCLES) * CLK_NS;

    logic         clk;
    logic         rst_n;
    logic         cpu_clk_en;
    logic         ppu_clk_en;
    cpu_bus_t     bus;
    status_evt_t  status_evt;
    logic         cpu_cyc_par;
    logic [7:0]   cpu_rd_data;
    logic [7:0]   reg_data_out;
    render_regs_t render;
    logic         cpu_suspend;
    logic [15:0]  cpu_addr;
    logic         cpu_re;

    int           errors;
    int           ph;
    logic [31:0]  rng;
    logic         rd_pend;
    logic [15:0]  rd_addr;
    logic [7:0]   exp_page;
    logic         dma_window;
    logic [7:0]   vram_model [2048];
    logic [7:0]   pal_model [32];

    tb_clock clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ppu_reg_top #(
        .VRAM_AW (11)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_clk_en   (cpu_clk_en),
        .ppu_clk_en   (ppu_clk_en),
        .bus          (bus),
        .status_evt   (status_evt),
        .cpu_cyc_par  (cpu_cyc_par),
        .cpu_rd_data  (cpu_rd_data),
        .reg_data_out (reg_data_out),
        .render       (render),
        .cpu_suspend  (cpu_suspend),
        .cpu_addr     (cpu_addr),
        .cpu_re       (cpu_re)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // cpu ram pattern, page byte xor low byte
    function automatic logic [7:0] ram_byte(input logic [15:0] addr);
        return addr[15:8] ^ addr[7:0];
    endfunction

    task automatic next_byte(output logic [7:0] b);
        rng = xorshift(rng);
        b = rng[7:0];
    endtask

    task automatic check8(input string name, input logic [7:0] got, input logic [7:0] want);
        assert (got === want) else begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, want);
        end
    endtask

    task automatic check_int(input string name, input int got, input int want);
        assert (got == want) else begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, want);
        end
    endtask

    // one clock; cpu enable every third cycle, ram answers a cycle later
    task automatic step();
        @(negedge clk);
        if (cpu_clk_en && rd_pend) begin
            cpu_rd_data = ram_byte(rd_addr);
        end
        ph = (ph == 2) ? 0 : ph + 1;
        cpu_clk_en = ph == 0;
        rd_pend = cpu_clk_en && cpu_re;
        rd_addr = cpu_addr;
    endtask

    task automatic cpu_access(input logic rw, input reg_sel_t sel, input logic [7:0] wdata);
        step();
        while (!cpu_clk_en) begin
            step();
        end
        bus.en    = 1'b1;
        bus.rw    = rw;
        bus.sel   = sel;
        bus.wdata = wdata;
        step();
        bus = '0;
    endtask

    task automatic cpu_write(input reg_sel_t sel, input logic [7:0] d);
        cpu_access(1'b1, sel, d);
    endtask

    task automatic cpu_read(input reg_sel_t sel, output logic [7:0] d);
        cpu_access(1'b0, sel, 8'h00);
        d = reg_data_out;
    endtask

    task automatic set_ppu_addr(input logic [15:0] a);
        cpu_write(PPUADDR, a[15:8]);
        cpu_write(PPUADDR, a[7:0]);
    endtask

    task automatic pulse_evt(input status_evt_t e);
        step();
        status_evt = e;
        step();
        status_evt = '0;
    endtask

    task automatic test_render();
        logic [7:0] c;
        logic [7:0] m;
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] x2;
        logic [7:0] d;
        next_byte(c);
        next_byte(m);
        next_byte(x);
        next_byte(y);
        next_byte(x2);
        cpu_write(PPUCTRL, c);
        cpu_write(PPUMASK, m);
        check8("render.ctrl", render.ctrl, c);
        check8("render.mask", render.mask, m);
        cpu_write(PPUSCROLL, x);
        cpu_write(PPUSCROLL, y);
        check8("render.scroll_x", render.scroll_x, x);
        check8("render.scroll_y", render.scroll_y, y);
        // half a pair, then status read puts the toggle back on x
        cpu_write(PPUSCROLL, y);
        cpu_read(PPUSTATUS, d);
        cpu_write(PPUSCROLL, x2);
        check8("render.scroll_x", render.scroll_x, x2);
        check8("render.scroll_y", render.scroll_y, 8'h00);
    endtask

    task automatic test_ppudata();
        logic [15:0] base;
        logic [15:0] a;
        logic [15:0] oor;
        logic [7:0]  d;
        logic [7:0]  prev;
        cpu_write(PPUCTRL, 8'h00);
        rng = xorshift(rng);
        base = {5'b00100, rng[10:0]};
        a = base;
        set_ppu_addr(base);
        for (int i = 0; i < N_DATA; i++) begin
            next_byte(d);
            vram_model[a[10:0]] = d;
            cpu_write(PPUDATA, d);
            a = a + 16'd1;
        end
        a = base;
        set_ppu_addr(base);
        for (int i = 0; i < N_DATA; i++) begin
            cpu_read(PPUDATA, d);
            check8("reg_data_out", d, vram_model[a[10:0]]);
            a = a + 16'd1;
        end
        // one byte straight from its predicted address
        a = base + 16'd9;
        set_ppu_addr(a);
        cpu_read(PPUDATA, d);
        check8("reg_data_out", d, vram_model[a[10:0]]);
        set_ppu_addr(16'h3f00);
        for (int k = 0; k < N_PAL; k++) begin
            next_byte(d);
            pal_model[k] = d;
            cpu_write(PPUDATA, d);
        end
        set_ppu_addr(16'h3f00);
        for (int k = 0; k < N_PAL; k++) begin
            cpu_read(PPUDATA, d);
            check8("reg_data_out", d, pal_model[k]);
        end
        // stride of 32, one nametable row per write
        cpu_write(PPUCTRL, 8'h04);
        a = 16'h2405;
        set_ppu_addr(a);
        for (int k = 0; k < 4; k++) begin
            next_byte(d);
            vram_model[a[10:0]] = d;
            cpu_write(PPUDATA, d);
            a = a + 16'd32;
        end
        cpu_write(PPUCTRL, 8'h00);
        a = 16'h2405;
        for (int k = 0; k < 4; k++) begin
            set_ppu_addr(a);
            cpu_read(PPUDATA, d);
            check8("reg_data_out", d, vram_model[a[10:0]]);
            a = a + 16'd32;
        end
        // below 0x2000 shares the low bits with base but must not reach vram
        oor = {5'b00000, base[10:0]};
        set_ppu_addr(base);
        cpu_read(PPUDATA, prev);
        check8("reg_data_out", prev, vram_model[base[10:0]]);
        set_ppu_addr(oor);
        cpu_write(PPUDATA, ~vram_model[base[10:0]]);
        set_ppu_addr(oor);
        cpu_read(PPUDATA, d);
        check8("reg_data_out", d, vram_model[base[10:0]]);
        set_ppu_addr(base);
        cpu_read(PPUDATA, d);
        check8("reg_data_out", d, vram_model[base[10:0]]);
    endtask

    task automatic test_oamdata();
        logic [7:0] b;
        logic [7:0] d;
        logic [7:0] want [N_DATA];
        next_byte(b);
        cpu_write(OAMADDR, b);
        for (int i = 0; i < N_DATA; i++) begin
            next_byte(d);
            want[i] = d;
            cpu_write(OAMDATA, d);
        end
        cpu_write(OAMADDR, b);
        for (int i = 0; i < N_DATA; i++) begin
            cpu_read(OAMDATA, d);
            check8("reg_data_out", d, want[i]);
        end
    endtask

    task automatic test_status();
        logic [7:0]  w;
        logic [7:0]  d;
        status_evt_t evt;
        next_byte(w);
        cpu_write(OAMADDR, w);
        evt = '0;
        evt.sp_over_set = 1'b1;
        evt.sp_zero_set = 1'b1;
        evt.vblank_set  = 1'b1;
        pulse_evt(evt);
        cpu_read(PPUSTATUS, d);
        check8("reg_data_out", d, {3'b111, w[4:0]});
        // the first read clears vblank two ppu cycles later
        cpu_read(PPUSTATUS, d);
        check8("reg_data_out", d, {3'b011, w[4:0]});
        evt = '0;
        evt.sp_over_clr = 1'b1;
        pulse_evt(evt);
        cpu_read(PPUSTATUS, d);
        check8("reg_data_out", d, {3'b010, w[4:0]});
        evt = '0;
        evt.sp_zero_clr = 1'b1;
        pulse_evt(evt);
        cpu_read(PPUSTATUS, d);
        check8("reg_data_out", d, {3'b000, w[4:0]});
        evt = '0;
        evt.vblank_set = 1'b1;
        pulse_evt(evt);
        evt = '0;
        evt.vblank_clr = 1'b1;
        pulse_evt(evt);
        cpu_read(PPUSTATUS, d);
        check8("reg_data_out", d, {3'b000, w[4:0]});
    endtask

    task automatic test_dma(input logic par);
        logic [7:0] base;
        logic [7:0] page;
        logic [7:0] d;
        logic [7:0] j;
        logic       done;
        int         n_susp;
        next_byte(base);
        next_byte(page);
        cpu_write(OAMADDR, base);
        cpu_cyc_par = par;
        exp_page = page;
        dma_window = 1'b1;
        n_susp = 0;
        done = 1'b0;
        cpu_write(OAMDMA, page);
        while (!done) begin
            step();
            if (cpu_clk_en) begin
                if (cpu_suspend) begin
                    n_susp++;
                end else begin
                    done = 1'b1;
                end
            end
        end
        // cpu is free on the last write, a second start there is ignored
        bus.en    = 1'b1;
        bus.rw    = 1'b1;
        bus.sel   = OAMDMA;
        bus.wdata = page;
        step();
        bus = '0;
        dma_window = 1'b0;
        check_int("cpu_suspend cycles", n_susp, par ? 513 : 512);
        // oam slot base+n holds ram byte n of the page
        cpu_write(OAMADDR, 8'h00);
        j = 8'h00;
        for (int i = 0; i < 256; i++) begin
            cpu_read(OAMDATA, d);
            check8("reg_data_out", d, page ^ (j - base));
            j = j + 8'd1;
        end
    endtask

    a_dma_page: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_re |-> cpu_addr[15:8] == exp_page)
        else begin
            errors++;
            $display("ERR cpu_addr got %h expected page %h", cpu_addr, exp_page);
        end

    a_suspend_in_dma: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_suspend |-> dma_window)
        else begin
            errors++;
            $display("cpu_suspend rose while no dma was started");
        end

    initial begin
        errors      = 0;
        ph          = 0;
        rng         = 32'hb264_dd6d;
        cpu_clk_en  = 1'b0;
        ppu_clk_en  = 1'b1;
        bus         = '0;
        status_evt  = '0;
        cpu_cyc_par = 1'b0;
        cpu_rd_data = 8'h00;
        rd_pend     = 1'b0;
        rd_addr     = 16'h0000;
        exp_page    = 8'h00;
        dma_window  = 1'b0;
        wait (rst_n === 1'b1);
        test_render();
        test_ppudata();
        test_oamdata();
        test_status();
        test_dma(1'b0);
        test_dma(1'b1);
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: verilog/oam_dma.sv
`timescale 1ns/1ns
`default_nettype none

module oam_dma (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cpu_clk_en,
    input  logic              dma_start,
    input  logic [7:0]        dma_page,
    input  logic [7:0]        oam_base,
    input  logic              cpu_cyc_par,
    input  logic [7:0]        cpu_rd_data,
    output logic              cpu_suspend,
    output logic [15:0]       cpu_addr,
    output logic              cpu_re,
    output ppu_pkg::oam_req_t dma_oam
);
    typedef enum logic [2:0] {
        S_IDLE,
        S_DUMMY1,
        S_DUMMY2,
        S_READ,
        S_WRITE
    } dma_state_t;

    dma_state_t state;
    dma_state_t state_nxt;
    logic [7:0] cnt;
    logic       last;

    assign last = cnt == 8'hff;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            cnt   <= 8'h00;
        end else if (cpu_clk_en) begin
            state <= state_nxt;
            if (state == S_DUMMY1) begin
                cnt <= 8'h00;
            end else if (state == S_WRITE && !last) begin
                cnt <= cnt + 8'd1;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (dma_start) begin
                    state_nxt = S_DUMMY1;
                end
            end
            // odd cpu cycle needs one more alignment cycle
            S_DUMMY1: state_nxt = cpu_cyc_par ? S_DUMMY2 : S_READ;
            S_DUMMY2: state_nxt = S_READ;
            S_READ: state_nxt = S_WRITE;
            S_WRITE: state_nxt = last ? S_IDLE : S_READ;
            default: state_nxt = S_IDLE;
        endcase
    end

    // cpu resumes during the final write
    assign cpu_suspend = state != S_IDLE && !(state == S_WRITE && last);
    assign cpu_addr    = {dma_page, cnt};
    assign cpu_re      = state == S_READ;

    // ram data from the read cycle is valid here
    assign dma_oam.addr  = oam_base + cnt;
    assign dma_oam.we    = cpu_clk_en && state == S_WRITE;
    assign dma_oam.re    = 1'b0;
    assign dma_oam.wdata = cpu_rd_data;

    // back in idle with the cpu released once the last byte is written
    a_idle_no_suspend: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_clk_en && state == S_WRITE && last) |=> state == S_IDLE && !cpu_suspend)
        else $error("ERR cpu_suspend or state wrong after last write, cnt=%h", cnt);

    a_busy_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_clk_en && dma_start && state != S_IDLE && state != S_DUMMY1)
        |=> state != S_DUMMY1 && cnt >= $past(cnt))
        else $error("ERR dma_start restarted busy dma, cnt=%h", cnt);

endmodule

`default_nettype wire

// File: verilog/ppu_mem.sv
`timescale 1ns/1ns
`default_nettype none

module ppu_mem #(
    parameter int VRAM_AW = 11
) (
    input  logic              clk,
    input  ppu_pkg::oam_req_t reg_oam,
    input  ppu_pkg::oam_req_t dma_oam,
    input  ppu_pkg::ppu_req_t ppu_req,
    output logic [7:0]        oam_rd,
    output logic [7:0]        vram_rd,
    output logic [7:0]        pal_rd
);
    logic [7:0] oam_mem [256];
    logic [7:0] vram_mem [2**VRAM_AW];
    logic [7:0] pal_mem [32];

    logic       oam_we;
    logic [7:0] oam_waddr;
    logic [7:0] oam_wdata;

    // dma owns the oam write port while it writes
    assign oam_we    = dma_oam.we || reg_oam.we;
    assign oam_waddr = dma_oam.we ? dma_oam.addr : reg_oam.addr;
    assign oam_wdata = dma_oam.we ? dma_oam.wdata : reg_oam.wdata;

    always_ff @(posedge clk) begin
        if (oam_we) begin
            oam_mem[oam_waddr] <= oam_wdata;
        end
        if (ppu_req.vram_we) begin
            vram_mem[ppu_req.addr[VRAM_AW-1:0]] <= ppu_req.wdata;
        end
        if (ppu_req.pal_we) begin
            pal_mem[ppu_req.addr[4:0]] <= ppu_req.wdata;
        end
    end

    // nametable mirroring falls out of the low address bits
    assign oam_rd  = reg_oam.re ? oam_mem[reg_oam.addr] : 8'h00;
    assign vram_rd = ppu_req.vram_re ? vram_mem[ppu_req.addr[VRAM_AW-1:0]] : 8'h00;
    assign pal_rd  = ppu_req.pal_re ? pal_mem[ppu_req.addr[4:0]] : 8'h00;

    a_oam_addr_known: assert property (@(posedge clk)
        oam_we |-> !$isunknown(oam_waddr))
        else $error("ERR oam_waddr unknown on write, dma_we=%h", dma_oam.we);

endmodule

`default_nettype wire

// File: verilog/ppu_pkg.sv
`default_nettype none

package ppu_pkg;

    // cpu-visible registers, NES order, OAMDMA last
    typedef enum logic [3:0] {
        PPUCTRL   = 4'd0,
        PPUMASK   = 4'd1,
        PPUSTATUS = 4'd2,
        OAMADDR   = 4'd3,
        OAMDATA   = 4'd4,
        PPUSCROLL = 4'd5,
        PPUADDR   = 4'd6,
        PPUDATA   = 4'd7,
        OAMDMA    = 4'd8
    } reg_sel_t;

    // rw: 1 is write
    typedef struct packed {
        logic       en;
        logic       rw;
        reg_sel_t   sel;
        logic [7:0] wdata;
    } cpu_bus_t;

    typedef struct packed {
        logic sp_over_set;
        logic sp_over_clr;
        logic sp_zero_set;
        logic sp_zero_clr;
        logic vblank_set;
        logic vblank_clr;
    } status_evt_t;

    typedef struct packed {
        logic [7:0] ctrl;
        logic [7:0] mask;
        logic [7:0] scroll_x;
        logic [7:0] scroll_y;
    } render_regs_t;

    typedef struct packed {
        logic [7:0] addr;
        logic       we;
        logic       re;
        logic [7:0] wdata;
    } oam_req_t;

    // addr is the full ppu address, the memory picks its own bits
    typedef struct packed {
        logic [15:0] addr;
        logic        vram_we;
        logic        vram_re;
        logic        pal_we;
        logic        pal_re;
        logic [7:0]  wdata;
    } ppu_req_t;

endpackage

`default_nettype wire

// File: verilog/ppu_reg_top.sv
`timescale 1ns/1ns
`default_nettype none

module ppu_reg_top #(
    parameter int VRAM_AW = 11
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cpu_clk_en,
    input  logic                  ppu_clk_en,
    input  ppu_pkg::cpu_bus_t     bus,
    input  ppu_pkg::status_evt_t  status_evt,
    input  logic                  cpu_cyc_par,
    input  logic [7:0]            cpu_rd_data,
    output logic [7:0]            reg_data_out,
    output ppu_pkg::render_regs_t render,
    output logic                  cpu_suspend,
    output logic [15:0]           cpu_addr,
    output logic                  cpu_re
);
    import ppu_pkg::*;

    oam_req_t   reg_oam;
    oam_req_t   dma_oam;
    ppu_req_t   ppu_req;
    logic [7:0] oam_rd;
    logic [7:0] vram_rd;
    logic [7:0] pal_rd;
    logic       dma_start;
    logic [7:0] dma_page;
    logic [7:0] oam_base;

    ppu_regs u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_clk_en   (cpu_clk_en),
        .ppu_clk_en   (ppu_clk_en),
        .bus          (bus),
        .status_evt   (status_evt),
        .oam_rd       (oam_rd),
        .vram_rd      (vram_rd),
        .pal_rd       (pal_rd),
        .reg_data_out (reg_data_out),
        .render       (render),
        .reg_oam      (reg_oam),
        .ppu_req      (ppu_req),
        .dma_start    (dma_start),
        .dma_page     (dma_page),
        .oam_base     (oam_base)
    );

    oam_dma u_dma (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_clk_en  (cpu_clk_en),
        .dma_start   (dma_start),
        .dma_page    (dma_page),
        .oam_base    (oam_base),
        .cpu_cyc_par (cpu_cyc_par),
        .cpu_rd_data (cpu_rd_data),
        .cpu_suspend (cpu_suspend),
        .cpu_addr    (cpu_addr),
        .cpu_re      (cpu_re),
        .dma_oam     (dma_oam)
    );

    ppu_mem #(
        .VRAM_AW (VRAM_AW)
    ) u_mem (
        .clk     (clk),
        .reg_oam (reg_oam),
        .dma_oam (dma_oam),
        .ppu_req (ppu_req),
        .oam_rd  (oam_rd),
        .vram_rd (vram_rd),
        .pal_rd  (pal_rd)
    );

endmodule

`default_nettype wire

// File: verilog/ppu_regs.sv
`timescale 1ns/1ns
`default_nettype none

module ppu_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cpu_clk_en,
    input  logic                  ppu_clk_en,
    input  ppu_pkg::cpu_bus_t     bus,
    input  ppu_pkg::status_evt_t  status_evt,
    input  logic [7:0]            oam_rd,
    input  logic [7:0]            vram_rd,
    input  logic [7:0]            pal_rd,
    output logic [7:0]            reg_data_out,
    output ppu_pkg::render_regs_t render,
    output ppu_pkg::oam_req_t     reg_oam,
    output ppu_pkg::ppu_req_t     ppu_req,
    output logic                  dma_start,
    output logic [7:0]            dma_page,
    output logic [7:0]            oam_base
);
    import ppu_pkg::*;

    logic        acc_wr;
    logic        acc_rd;
    logic        stat_rd;
    logic [7:0]  ctrl;
    logic [7:0]  mask;
    logic [7:0]  scroll_x;
    logic [7:0]  scroll_y;
    logic [7:0]  oam_addr;
    logic [15:0] ppu_addr;
    logic [15:0] addr_inc;
    logic        scroll_tgl;
    logic        addr_tgl;
    logic [4:0]  last_wr;
    logic        in_vram;
    logic        in_pal;
    logic        vblank;
    logic        sp_zero;
    logic        sp_over;
    logic [4:0]  stat_lo;
    logic        clr_d0;
    logic        clr_d1;
    logic [7:0]  status;

    assign acc_wr  = cpu_clk_en && bus.en && bus.rw;
    assign acc_rd  = cpu_clk_en && bus.en && !bus.rw;
    assign stat_rd = acc_rd && bus.sel == PPUSTATUS;

    assign addr_inc = ctrl[2] ? 16'd32 : 16'd1;
    assign in_vram  = ppu_addr >= 16'h2000 && ppu_addr <= 16'h3eff;
    assign in_pal   = ppu_addr[15:8] == 8'h3f;
    assign status   = {vblank, sp_zero, sp_over, stat_lo};

    assign render.ctrl     = ctrl;
    assign render.mask     = mask;
    assign render.scroll_x = scroll_x;
    assign render.scroll_y = scroll_y;

    assign reg_oam.addr  = oam_addr;
    assign reg_oam.we    = acc_wr && bus.sel == OAMDATA;
    assign reg_oam.re    = acc_rd && bus.sel == OAMDATA;
    assign reg_oam.wdata = bus.wdata;

    // out-of-range PPUDATA accesses raise no strobe
    assign ppu_req.addr    = ppu_addr;
    assign ppu_req.vram_we = acc_wr && bus.sel == PPUDATA && in_vram;
    assign ppu_req.vram_re = acc_rd && bus.sel == PPUDATA && in_vram;
    assign ppu_req.pal_we  = acc_wr && bus.sel == PPUDATA && in_pal;
    assign ppu_req.pal_re  = acc_rd && bus.sel == PPUDATA && in_pal;
    assign ppu_req.wdata   = bus.wdata;

    assign dma_start = acc_wr && bus.sel == OAMDMA;
    assign oam_base  = oam_addr;

    // cpu side, all updates on cpu-enabled edges
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl         <= 8'h00;
            mask         <= 8'h00;
            scroll_x     <= 8'h00;
            scroll_y     <= 8'h00;
            oam_addr     <= 8'h00;
            ppu_addr     <= 16'h0000;
            scroll_tgl   <= 1'b0;
            addr_tgl     <= 1'b0;
            last_wr      <= 5'h00;
            dma_page     <= 8'h00;
            reg_data_out <= 8'h00;
        end else if (acc_wr) begin
            last_wr <= bus.wdata[4:0];
            case (bus.sel)
                PPUCTRL: ctrl <= bus.wdata;
                PPUMASK: mask <= bus.wdata;
                OAMADDR: oam_addr <= bus.wdata;
                OAMDATA: oam_addr <= oam_addr + 8'd1;
                PPUSCROLL: begin
                    if (scroll_tgl) begin
                        scroll_y <= bus.wdata;
                    end else begin
                        scroll_x <= bus.wdata;
                    end
                    scroll_tgl <= !scroll_tgl;
                end
                PPUADDR: begin
                    // high byte first
                    if (addr_tgl) begin
                        ppu_addr[7:0] <= bus.wdata;
                    end else begin
                        ppu_addr[15:8] <= bus.wdata;
                    end
                    addr_tgl <= !addr_tgl;
                end
                PPUDATA: ppu_addr <= ppu_addr + addr_inc;
                OAMDMA: dma_page <= bus.wdata;
                default: ;
            endcase
        end else if (acc_rd) begin
            case (bus.sel)
                PPUSTATUS: begin
                    reg_data_out <= status;
                    scroll_tgl   <= 1'b0;
                    addr_tgl     <= 1'b0;
                    scroll_x     <= 8'h00;
                    scroll_y     <= 8'h00;
                    ppu_addr     <= 16'h0000;
                end
                OAMDATA: begin
                    reg_data_out <= oam_rd;
                    oam_addr     <= oam_addr + 8'd1;
                end
                PPUDATA: begin
                    // unbuffered read
                    if (in_vram) begin
                        reg_data_out <= vram_rd;
                    end else if (in_pal) begin
                        reg_data_out <= pal_rd;
                    end
                    ppu_addr <= ppu_addr + addr_inc;
                end
                default: ;
            endcase
        end
    end

    // renderer side, flags move on ppu-enabled edges
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vblank  <= 1'b0;
            sp_zero <= 1'b0;
            sp_over <= 1'b0;
            stat_lo <= 5'h00;
            clr_d0  <= 1'b0;
            clr_d1  <= 1'b0;
        end else if (ppu_clk_en) begin
            stat_lo <= last_wr;
            clr_d0  <= stat_rd;
            clr_d1  <= clr_d0;
            if (status_evt.sp_over_set) begin
                sp_over <= 1'b1;
            end
            if (status_evt.sp_over_clr) begin
                sp_over <= 1'b0;
            end
            if (status_evt.sp_zero_set) begin
                sp_zero <= 1'b1;
            end
            if (status_evt.sp_zero_clr) begin
                sp_zero <= 1'b0;
            end
            if (status_evt.vblank_clr || clr_d1) begin
                vblank <= 1'b0;
            end
            // a fresh vblank cancels the pending read clear
            if (status_evt.vblank_set) begin
                vblank <= 1'b1;
                clr_d1 <= 1'b0;
            end
        end else if (stat_rd) begin
            // hold the read until the next ppu cycle sees it
            clr_d0 <= 1'b1;
        end
    end

    a_data_one_target: assert property (@(posedge clk) disable iff (!rst_n)
        !(ppu_req.vram_we && ppu_req.pal_we))
        else $error("ERR ppu_req vram_we pal_we both set, addr=%h", ppu_req.addr);

endmodule

`default_nettype wire
